/* Makefile */
SRCS := $(shell cat files.f)

.PHONY: run check clean

obj_dir/Vtb_top: files.f $(SRCS)
	verilator --binary --timing -f files.f --top-module tb_top

sim.log: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log

run: sim.log
	! grep -q "TEST RESULT: FAIL" sim.log

check: run
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
sdram_pkg.sv
sdram_bank_mux.sv
sdram_bank_ctl.sv
sdram_store.sv
sdram_sub_top.sv
tb_checker.sv
tb_top.sv

/* sdram_bank_ctl.sv */
module sdram_bank_ctl #(
    parameter int AW          = 22,
    parameter int MEM_AW      = 10,
    parameter int RD_LAT      = 4,
    parameter int RFSH_PERIOD = 64,
    parameter int RFSH_LEN    = 4
) (
    input  logic               rst,
    input  logic               clk,

    // command from the mux
    input  logic [AW-1:0]      ctl_addr,
    input  logic               ctl_rd,
    input  logic               ctl_wr,
    input  sdram_pkg::bank_t   ctl_ba_rq,
    input  sdram_pkg::word_t   ctl_din,
    input  sdram_pkg::mask_t   ctl_din_m,
    input  logic               ctl_rfsh_en,
    output logic               ctl_ack,
    output logic               ctl_rdy,
    output sdram_pkg::bank_t   ctl_ba_rdy,
    output sdram_pkg::dword_t  ctl_dout,

    // word store
    output logic               st_we,
    output logic               st_re,
    output logic [MEM_AW+1:0]  st_addr,
    output sdram_pkg::word_t   st_din,
    output sdram_pkg::mask_t   st_din_m,
    input  sdram_pkg::dword_t  st_dout
);

    localparam int PCW = $clog2(RFSH_PERIOD + 1);
    localparam int LCW = $clog2(RFSH_LEN + 1);

    sdram_pkg::ctl_state_e state;

    logic [PCW-1:0]    rfsh_cnt;
    logic              rfsh_due;
    logic [LCW-1:0]    len_cnt;   // cycles left in the burst

    logic [3:0]        busy;
    logic [3:0]        ack_mask;
    logic [3:0]        rdy_mask;

    // latency pipeline, stage RD_LAT-1 is the result
    logic [RD_LAT-1:0] pipe_vld;
    sdram_pkg::bank_t  pipe_ba  [0:RD_LAT-1];
    sdram_pkg::dword_t dat_pipe [1:RD_LAT-1];

    assign ctl_ack = (ctl_rd || ctl_wr) && state == sdram_pkg::ctl_idle
                     && !busy[ctl_ba_rq];

    assign ack_mask = ctl_ack ? (4'b0001 << ctl_ba_rq) : 4'b0000;
    assign rdy_mask = ctl_rdy ? (4'b0001 << ctl_ba_rdy) : 4'b0000;

    // store access happens at the accepting edge
    assign st_we    = ctl_ack && ctl_wr;
    assign st_re    = ctl_ack && ctl_rd;
    assign st_addr  = {ctl_ba_rq, ctl_addr[MEM_AW-1:0]};
    assign st_din   = ctl_din;
    assign st_din_m = ctl_din_m;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= sdram_pkg::ctl_idle;
            rfsh_cnt <= '0;
            rfsh_due <= 1'b0;
            len_cnt  <= '0;
        end else begin
            case (state)
                sdram_pkg::ctl_idle: begin
                    if (rfsh_due && ctl_rfsh_en)
                        state <= sdram_pkg::ctl_drain;
                end
                sdram_pkg::ctl_drain: begin
                    if (busy == 4'b0000) begin   // all reads delivered
                        state    <= sdram_pkg::ctl_refresh;
                        len_cnt  <= LCW'(RFSH_LEN - 1);
                        rfsh_due <= 1'b0;
                    end
                end
                sdram_pkg::ctl_refresh: begin
                    if (len_cnt == '0)
                        state <= sdram_pkg::ctl_idle;
                    else
                        len_cnt <= len_cnt - 1'b1;
                end
                default: state <= sdram_pkg::ctl_idle;
            endcase
            // period tick wins over the clear above
            if (rfsh_cnt == PCW'(RFSH_PERIOD - 1)) begin
                rfsh_cnt <= '0;
                rfsh_due <= 1'b1;
            end else begin
                rfsh_cnt <= rfsh_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy     <= 4'b0000;
            pipe_vld <= '0;
        end else begin
            busy     <= (busy & ~rdy_mask) | ack_mask;
            pipe_vld <= {pipe_vld[RD_LAT-2:0], ctl_ack};
        end
    end

    always_ff @(posedge clk) begin
        pipe_ba[0]  <= ctl_ba_rq;
        dat_pipe[1] <= st_dout;   // store output is valid one cycle after ack
        for (int i = 1; i < RD_LAT; i++) begin
            pipe_ba[i] <= pipe_ba[i-1];
        end
        for (int i = 2; i < RD_LAT; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    assign ctl_rdy    = pipe_vld[RD_LAT-1];
    assign ctl_ba_rdy = pipe_ba[RD_LAT-1];
    assign ctl_dout   = dat_pipe[RD_LAT-1];

endmodule

/* sdram_bank_mux.sv */
module sdram_bank_mux #(
    parameter int AW = 22
) (
    input  logic               rst,
    input  logic               clk,

    // bank 0, read and write
    input  logic [AW-1:0]      ba0_addr,
    input  logic               ba0_rd,
    input  logic               ba0_wr,
    input  sdram_pkg::word_t   ba0_din,
    input  sdram_pkg::mask_t   ba0_din_m,
    output logic               ba0_ack,
    output logic               ba0_rdy,

    // banks 1 to 3, read only
    input  logic [AW-1:0]      ba1_addr,
    input  logic               ba1_rd,
    output logic               ba1_ack,
    output logic               ba1_rdy,
    input  logic [AW-1:0]      ba2_addr,
    input  logic               ba2_rd,
    output logic               ba2_ack,
    output logic               ba2_rdy,
    input  logic [AW-1:0]      ba3_addr,
    input  logic               ba3_rd,
    output logic               ba3_ack,
    output logic               ba3_rdy,

    // rom download
    input  logic               prog_en,
    input  logic [AW-1:0]      prog_addr,
    input  sdram_pkg::bank_t   prog_ba,
    input  logic               prog_rd,
    input  logic               prog_wr,
    input  sdram_pkg::word_t   prog_din,
    input  sdram_pkg::mask_t   prog_din_m,
    output logic               prog_rdy,

    // controller side
    output logic [AW-1:0]      ctl_addr,
    output logic               ctl_rd,
    output logic               ctl_wr,
    output sdram_pkg::bank_t   ctl_ba_rq,
    output sdram_pkg::word_t   ctl_din,
    output sdram_pkg::mask_t   ctl_din_m,
    output logic               ctl_rfsh_en,
    input  logic               ctl_ack,
    input  logic               ctl_rdy,
    input  sdram_pkg::bank_t   ctl_ba_rdy,
    input  sdram_pkg::dword_t  ctl_dout,

    input  logic               rfsh_en,
    output sdram_pkg::dword_t  dout
);

    // queue, entry 2 is the top and entry 0 feeds the controller
    logic [AW-1:0]     q_addr [0:2];
    sdram_pkg::bank_t  q_ba   [0:2];
    logic [2:0]        q_rd;
    logic [2:0]        q_wr;
    logic [2:0]        q_vld;

    logic [3:0]        queued;   // bank has a request in queue or in flight
    logic [3:0]        free;
    logic [3:0]        rdy_mask;

    logic              shift_ok;
    logic              mid_shift_ok;
    logic              push_ok;

    // request picked for the queue top
    logic [AW-1:0]     new_addr;
    logic              new_rd;
    logic              new_wr;
    sdram_pkg::bank_t  new_ba;
    logic [3:0]        new_set;

    logic              client_ack;
    logic              client_rdy;

    assign q_vld    = q_rd | q_wr;
    assign free     = ~queued;
    assign rdy_mask = ctl_rdy ? (4'b0001 << ctl_ba_rdy) : 4'b0000;

    assign shift_ok     = !q_vld[0] || ctl_ack;
    assign mid_shift_ok = !q_vld[1];   // bubble in the middle
    assign push_ok      = !q_vld[2] || shift_ok || mid_shift_ok;

    // fixed priority, lowest bank first
    always_comb begin
        new_addr = ba0_addr;
        new_rd   = 1'b0;
        new_wr   = 1'b0;
        new_ba   = 2'd0;
        new_set  = 4'b0000;
        if ((ba0_rd || ba0_wr) && free[0]) begin
            new_rd  = ba0_rd;
            new_wr  = ba0_wr;
            new_set = 4'b0001;
        end else if (ba1_rd && free[1]) begin
            new_addr = ba1_addr;
            new_rd   = 1'b1;
            new_ba   = 2'd1;
            new_set  = 4'b0010;
        end else if (ba2_rd && free[2]) begin
            new_addr = ba2_addr;
            new_rd   = 1'b1;
            new_ba   = 2'd2;
            new_set  = 4'b0100;
        end else if (ba3_rd && free[3]) begin
            new_addr = ba3_addr;
            new_rd   = 1'b1;
            new_ba   = 2'd3;
            new_set  = 4'b1000;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            q_rd   <= 3'b000;
            q_wr   <= 3'b000;
            queued <= 4'b0000;
        end else if (prog_en) begin
            q_rd   <= 3'b000;   // download owns the controller
            q_wr   <= 3'b000;
            queued <= 4'b0000;
        end else begin
            if (shift_ok) begin
                q_addr[0] <= q_addr[1];
                q_ba[0]   <= q_ba[1];
                q_rd[0]   <= q_rd[1];
                q_wr[0]   <= q_wr[1];
            end
            if (shift_ok || mid_shift_ok) begin
                q_addr[1] <= q_addr[2];
                q_ba[1]   <= q_ba[2];
                q_rd[1]   <= q_rd[2];
                q_wr[1]   <= q_wr[2];
            end
            if (push_ok) begin
                q_addr[2] <= new_addr;
                q_ba[2]   <= new_ba;
                q_rd[2]   <= new_rd;   // empty slot if nobody asked
                q_wr[2]   <= new_wr;
            end
            queued <= (queued & ~rdy_mask) | (push_ok ? new_set : 4'b0000);
        end
    end

    // download overrides the queue output
    assign ctl_addr    = prog_en ? prog_addr  : q_addr[0];
    assign ctl_rd      = prog_en ? prog_rd    : q_rd[0];
    assign ctl_wr      = prog_en ? prog_wr    : q_wr[0];
    assign ctl_ba_rq   = prog_en ? prog_ba    : q_ba[0];
    assign ctl_din     = prog_en ? prog_din   : ba0_din;
    assign ctl_din_m   = prog_en ? prog_din_m : ba0_din_m;
    assign ctl_rfsh_en = prog_en | rfsh_en;

    assign prog_rdy = prog_en & ctl_ack;
    assign dout     = ctl_dout;

    assign client_ack = ctl_ack && !prog_en && q_vld[0];
    assign client_rdy = ctl_rdy && !prog_en;

    assign ba0_ack = client_ack && q_ba[0] == 2'd0;
    assign ba1_ack = client_ack && q_ba[0] == 2'd1;
    assign ba2_ack = client_ack && q_ba[0] == 2'd2;
    assign ba3_ack = client_ack && q_ba[0] == 2'd3;

    assign ba0_rdy = client_rdy && ctl_ba_rdy == 2'd0;
    assign ba1_rdy = client_rdy && ctl_ba_rdy == 2'd1;
    assign ba2_rdy = client_rdy && ctl_ba_rdy == 2'd2;
    assign ba3_rdy = client_rdy && ctl_ba_rdy == 2'd3;

endmodule

/* sdram_pkg.sv */
package sdram_pkg;

    // one sdram word, also the write data width
    typedef logic [15:0] word_t;

    // read data: low word at the even address, high word at the next one
    typedef logic [31:0] dword_t;

    // write mask, a set bit keeps its byte unchanged
    // bit 0 covers bits 7:0
    typedef logic [1:0] mask_t;

    // bank number
    typedef logic [1:0] bank_t;

    // controller states
    typedef enum logic [1:0] {
        ctl_idle,    // taking commands
        ctl_drain,   // refresh pending, waiting for banks to go idle
        ctl_refresh  // refresh burst running
    } ctl_state_e;

endpackage

/* sdram_store.sv */
module sdram_store #(
    parameter int AW_ST = 12   // bank bits on top of the word address
) (
    input  logic               clk,
    input  logic               st_we,
    input  logic               st_re,
    input  logic [AW_ST-1:0]   st_addr,
    input  sdram_pkg::word_t   st_din,
    input  sdram_pkg::mask_t   st_din_m,
    output sdram_pkg::dword_t  st_dout
);

    localparam int WORDS = 2 ** AW_ST;

    sdram_pkg::word_t  mem [0:WORDS-1];

    logic [AW_ST-3:0]  col_nxt;
    logic [AW_ST-1:0]  addr_nxt;

    // second word of the pair wraps inside the same bank
    assign col_nxt  = st_addr[AW_ST-3:0] + 1'b1;
    assign addr_nxt = {st_addr[AW_ST-1:AW_ST-2], col_nxt};

    always_ff @(posedge clk) begin
        if (st_we) begin
            if (!st_din_m[0])
                mem[st_addr][7:0] <= st_din[7:0];
            if (!st_din_m[1])
                mem[st_addr][15:8] <= st_din[15:8];
        end
        if (st_re)
            st_dout <= {mem[addr_nxt], mem[st_addr]};   // even word low
    end

endmodule

/* sdram_sub_top.sv */
module sdram_sub_top #(
    parameter int AW          = 22,
    parameter int MEM_AW      = 10,
    parameter int RD_LAT      = 4,
    parameter int RFSH_PERIOD = 64,
    parameter int RFSH_LEN    = 4
) (
    input  logic               rst,
    input  logic               clk,

    input  logic [AW-1:0]      ba0_addr,
    input  logic               ba0_rd,
    input  logic               ba0_wr,
    input  sdram_pkg::word_t   ba0_din,
    input  sdram_pkg::mask_t   ba0_din_m,
    output logic               ba0_ack,
    output logic               ba0_rdy,
    input  logic [AW-1:0]      ba1_addr,
    input  logic               ba1_rd,
    output logic               ba1_ack,
    output logic               ba1_rdy,
    input  logic [AW-1:0]      ba2_addr,
    input  logic               ba2_rd,
    output logic               ba2_ack,
    output logic               ba2_rdy,
    input  logic [AW-1:0]      ba3_addr,
    input  logic               ba3_rd,
    output logic               ba3_ack,
    output logic               ba3_rdy,

    input  logic               prog_en,
    input  logic [AW-1:0]      prog_addr,
    input  sdram_pkg::bank_t   prog_ba,
    input  logic               prog_rd,
    input  logic               prog_wr,
    input  sdram_pkg::word_t   prog_din,
    input  sdram_pkg::mask_t   prog_din_m,
    output logic               prog_rdy,

    input  logic               rfsh_en,
    output sdram_pkg::dword_t  dout
);

    // mux to controller
    logic [AW-1:0]      ctl_addr;
    logic               ctl_rd;
    logic               ctl_wr;
    sdram_pkg::bank_t   ctl_ba_rq;
    sdram_pkg::word_t   ctl_din;
    sdram_pkg::mask_t   ctl_din_m;
    logic               ctl_rfsh_en;
    logic               ctl_ack;
    logic               ctl_rdy;
    sdram_pkg::bank_t   ctl_ba_rdy;
    sdram_pkg::dword_t  ctl_dout;

    // controller to store
    logic               st_we;
    logic               st_re;
    logic [MEM_AW+1:0]  st_addr;
    sdram_pkg::word_t   st_din;
    sdram_pkg::mask_t   st_din_m;
    sdram_pkg::dword_t  st_dout;

    sdram_bank_mux #(
        .AW (AW)
    ) u_mux (
        .rst        (rst),
        .clk        (clk),
        .ba0_addr   (ba0_addr),
        .ba0_rd     (ba0_rd),
        .ba0_wr     (ba0_wr),
        .ba0_din    (ba0_din),
        .ba0_din_m  (ba0_din_m),
        .ba0_ack    (ba0_ack),
        .ba0_rdy    (ba0_rdy),
        .ba1_addr   (ba1_addr),
        .ba1_rd     (ba1_rd),
        .ba1_ack    (ba1_ack),
        .ba1_rdy    (ba1_rdy),
        .ba2_addr   (ba2_addr),
        .ba2_rd     (ba2_rd),
        .ba2_ack    (ba2_ack),
        .ba2_rdy    (ba2_rdy),
        .ba3_addr   (ba3_addr),
        .ba3_rd     (ba3_rd),
        .ba3_ack    (ba3_ack),
        .ba3_rdy    (ba3_rdy),
        .prog_en    (prog_en),
        .prog_addr  (prog_addr),
        .prog_ba    (prog_ba),
        .prog_rd    (prog_rd),
        .prog_wr    (prog_wr),
        .prog_din   (prog_din),
        .prog_din_m (prog_din_m),
        .prog_rdy   (prog_rdy),
        .ctl_addr   (ctl_addr),
        .ctl_rd     (ctl_rd),
        .ctl_wr     (ctl_wr),
        .ctl_ba_rq  (ctl_ba_rq),
        .ctl_din    (ctl_din),
        .ctl_din_m  (ctl_din_m),
        .ctl_rfsh_en(ctl_rfsh_en),
        .ctl_ack    (ctl_ack),
        .ctl_rdy    (ctl_rdy),
        .ctl_ba_rdy (ctl_ba_rdy),
        .ctl_dout   (ctl_dout),
        .rfsh_en    (rfsh_en),
        .dout       (dout)
    );

    sdram_bank_ctl #(
        .AW          (AW),
        .MEM_AW      (MEM_AW),
        .RD_LAT      (RD_LAT),
        .RFSH_PERIOD (RFSH_PERIOD),
        .RFSH_LEN    (RFSH_LEN)
    ) u_ctl (
        .rst        (rst),
        .clk        (clk),
        .ctl_addr   (ctl_addr),
        .ctl_rd     (ctl_rd),
        .ctl_wr     (ctl_wr),
        .ctl_ba_rq  (ctl_ba_rq),
        .ctl_din    (ctl_din),
        .ctl_din_m  (ctl_din_m),
        .ctl_rfsh_en(ctl_rfsh_en),
        .ctl_ack    (ctl_ack),
        .ctl_rdy    (ctl_rdy),
        .ctl_ba_rdy (ctl_ba_rdy),
        .ctl_dout   (ctl_dout),
        .st_we      (st_we),
        .st_re      (st_re),
        .st_addr    (st_addr),
        .st_din     (st_din),
        .st_din_m   (st_din_m),
        .st_dout    (st_dout)
    );

    // two bank bits above the per-bank word address
    sdram_store #(
        .AW_ST (MEM_AW + 2)
    ) u_store (
        .clk      (clk),
        .st_we    (st_we),
        .st_re    (st_re),
        .st_addr  (st_addr),
        .st_din   (st_din),
        .st_din_m (st_din_m),
        .st_dout  (st_dout)
    );

endmodule

/* tb_checker.sv */
module tb_checker #(
    parameter int AW     = 22,
    parameter int MEM_AW = 6,
    parameter int RD_LAT = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [AW-1:0]      addr0,
    input  logic [AW-1:0]      addr1,
    input  logic [AW-1:0]      addr2,
    input  logic [AW-1:0]      addr3,
    input  logic [3:0]         req,        // rd per bank, rd or wr on bank 0
    input  logic               ba0_wr,
    input  sdram_pkg::word_t   ba0_din,
    input  sdram_pkg::mask_t   ba0_din_m,
    input  logic [3:0]         ack,
    input  logic [3:0]         rdy,
    input  logic               prog_wr,
    input  logic               prog_rdy,
    input  logic [AW-1:0]      prog_addr,
    input  sdram_pkg::bank_t   prog_ba,
    input  sdram_pkg::word_t   prog_din,
    input  sdram_pkg::mask_t   prog_din_m,
    input  sdram_pkg::dword_t  dout,
    output int                 errors,
    output int                 checks
);

    localparam int WORDS = 2 ** MEM_AW;

    sdram_pkg::word_t   shadow [0:4*WORDS-1];
    sdram_pkg::dword_t  exp_data [0:3];
    logic [AW-1:0]      addr [0:3];
    logic [3:0]         inflight;   // acked, rdy not yet seen
    logic [3:0]         acked;      // current request already acked
    logic [3:0]         is_rd;
    logic [3:0]         req_q;
    int                 cyc;
    int                 ack_cyc [0:3];
    int                 req_cyc [0:3];   // cycle the request went high

    assign addr[0] = addr0;
    assign addr[1] = addr1;
    assign addr[2] = addr2;
    assign addr[3] = addr3;

    function automatic int word_index(input int b, input int col);
        return b * WORDS + (col % WORDS);
    endfunction

    // a set mask bit keeps the old byte
    function automatic sdram_pkg::word_t merge(input sdram_pkg::word_t old,
                                               input sdram_pkg::word_t d,
                                               input sdram_pkg::mask_t m);
        sdram_pkg::word_t r;
        r = old;
        if (!m[0])
            r[7:0] = d[7:0];
        if (!m[1])
            r[15:8] = d[15:8];
        return r;
    endfunction

    task automatic protocol_error(input int b, input string msg);
        errors++;
        $display("error at time %0t: bank %0d %s", $time, b, msg);
    endtask

    always @(posedge clk) begin
        int col;
        if (rst) begin
            errors   = 0;
            checks   = 0;
            cyc      = 0;
            inflight = '0;
            acked    = '0;
            req_q    = '0;
        end else begin
            cyc = cyc + 1;
            if (prog_rdy && prog_wr) begin
                col = int'(prog_addr[MEM_AW-1:0]);
                shadow[word_index(int'(prog_ba), col)] =
                    merge(shadow[word_index(int'(prog_ba), col)], prog_din, prog_din_m);
            end
            for (int b = 0; b < 4; b++) begin
                if (req[b] && !req_q[b])
                    req_cyc[b] = cyc;
                if (!req[b])
                    acked[b] = 1'b0;
                if (rdy[b]) begin
                    checks++;
                    if (!inflight[b]) begin
                        protocol_error(b, "got rdy with no request outstanding");
                    end else begin
                        if (cyc - ack_cyc[b] != RD_LAT) begin
                            errors++;
                            $display("FAIL %0t: bank %0d rdy %0d cycles after ack, expected %0d",
                                     $time, b, cyc - ack_cyc[b], RD_LAT);
                        end
                        if (is_rd[b] && dout !== exp_data[b]) begin
                            errors++;
                            $display("FAIL %0t: bank %0d read %h, expected %h",
                                     $time, b, dout, exp_data[b]);
                        end
                        inflight[b] = 1'b0;
                    end
                end
                if (ack[b]) begin
                    checks++;
                    if (!req[b] || acked[b] || inflight[b])
                        protocol_error(b, "got ack with no pending request");
                    for (int i = 0; i < b; i++) begin
                        if (req[i] && !acked[i] && req_cyc[i] <= req_cyc[b])
                            protocol_error(b, "acked ahead of a lower bank that asked first");
                    end
                    acked[b]    = 1'b1;
                    inflight[b] = 1'b1;
                    ack_cyc[b]  = cyc;
                    is_rd[b]    = !(b == 0 && ba0_wr);
                    col = int'(addr[b][MEM_AW-1:0]);
                    if (b == 0 && ba0_wr)
                        shadow[word_index(0, col)] =
                            merge(shadow[word_index(0, col)], ba0_din, ba0_din_m);
                    else
                        exp_data[b] = {shadow[word_index(b, col + 1)], shadow[word_index(b, col)]};
                end
            end
            req_q = req;
        end
    end

endmodule

/* tb_top.sv */
module tb_top;

    localparam int AW       = 22;
    localparam int MEM_AW   = 6;
    localparam int RD_LAT   = 4;
    localparam int RFSH_LEN = 4;
    localparam int WORDS    = 2 ** MEM_AW;   // words per bank

    // requests per test
    localparam int N_FILL = 8 * WORDS + 32;  // fill, masked writes, read back
    localparam int N_READ = 90;
    localparam int N_MIX  = 40;
    localparam int N_CONC = 100;
    localparam int N_RFSH = 100;
    localparam int CYCLE_LIMIT = (N_FILL + N_READ + N_MIX + N_CONC + N_RFSH)
                                 * (RD_LAT + 3 * RFSH_LEN + 20);

    logic               clk;
    logic               rst;
    logic [AW-1:0]      c_addr [0:3];
    logic [3:0]         c_rd;
    logic               ba0_wr;
    sdram_pkg::word_t   ba0_din;
    sdram_pkg::mask_t   ba0_din_m;
    logic [3:0]         c_ack;
    logic [3:0]         c_rdy;
    logic               prog_en;
    logic [AW-1:0]      prog_addr;
    sdram_pkg::bank_t   prog_ba;
    logic               prog_rd;
    logic               prog_wr;
    sdram_pkg::word_t   prog_din;
    sdram_pkg::mask_t   prog_din_m;
    logic               prog_rdy;
    logic               rfsh_en;
    sdram_pkg::dword_t  dout;
    int                 errors;
    int                 checks;
    int                 cycles;
    int                 err_mark;

    sdram_sub_top #(
        .AW          (AW),
        .MEM_AW      (MEM_AW),
        .RD_LAT      (RD_LAT),
        .RFSH_PERIOD (40),
        .RFSH_LEN    (RFSH_LEN)
    ) i_dut (
        .rst(rst), .clk(clk),
        .ba0_addr(c_addr[0]), .ba0_rd(c_rd[0]), .ba0_wr(ba0_wr),
        .ba0_din(ba0_din), .ba0_din_m(ba0_din_m), .ba0_ack(c_ack[0]), .ba0_rdy(c_rdy[0]),
        .ba1_addr(c_addr[1]), .ba1_rd(c_rd[1]), .ba1_ack(c_ack[1]), .ba1_rdy(c_rdy[1]),
        .ba2_addr(c_addr[2]), .ba2_rd(c_rd[2]), .ba2_ack(c_ack[2]), .ba2_rdy(c_rdy[2]),
        .ba3_addr(c_addr[3]), .ba3_rd(c_rd[3]), .ba3_ack(c_ack[3]), .ba3_rdy(c_rdy[3]),
        .prog_en(prog_en), .prog_addr(prog_addr), .prog_ba(prog_ba), .prog_rd(prog_rd),
        .prog_wr(prog_wr), .prog_din(prog_din), .prog_din_m(prog_din_m),
        .prog_rdy(prog_rdy), .rfsh_en(rfsh_en), .dout(dout)
    );

    tb_checker #(.AW(AW), .MEM_AW(MEM_AW), .RD_LAT(RD_LAT)) i_chk (
        .clk(clk), .rst(rst),
        .addr0(c_addr[0]), .addr1(c_addr[1]), .addr2(c_addr[2]), .addr3(c_addr[3]),
        .req({c_rd[3:1], c_rd[0] | ba0_wr}), .ba0_wr(ba0_wr),
        .ba0_din(ba0_din), .ba0_din_m(ba0_din_m), .ack(c_ack), .rdy(c_rdy),
        .prog_wr(prog_wr), .prog_rdy(prog_rdy), .prog_addr(prog_addr), .prog_ba(prog_ba),
        .prog_din(prog_din), .prog_din_m(prog_din_m), .dout(dout),
        .errors(errors), .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit from the request counts
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: a request did not complete within %0d cycles", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // one client request, held until its rdy
    task automatic access(input int b, input bit wr, input logic [AW-1:0] a,
                          input sdram_pkg::word_t d, input sdram_pkg::mask_t m);
        @(negedge clk);
        c_addr[b] = a;
        if (b == 0) begin
            ba0_wr    = wr;
            ba0_din   = d;
            ba0_din_m = m;
        end
        c_rd[b] = !wr;
        @(negedge clk);
        while (!c_rdy[b])
            @(negedge clk);
        c_rd[b] = 1'b0;
        if (b == 0)
            ba0_wr = 1'b0;
    endtask

    task automatic prog_write(input int b, input int a, input sdram_pkg::word_t d,
                              input sdram_pkg::mask_t m);
        @(negedge clk);
        prog_ba    = sdram_pkg::bank_t'(b);
        prog_addr  = AW'(a);
        prog_din   = d;
        prog_din_m = m;
        prog_wr    = 1'b1;
        @(posedge clk);
        while (!prog_rdy)   // ack is seen at the edge
            @(posedge clk);
        @(negedge clk);
        prog_wr = 1'b0;
    endtask

    task automatic read_bank(input int b);
        for (int a = 0; a < WORDS; a++)
            access(b, 1'b0, AW'(a), '0, '0);
    endtask

    task automatic random_traffic(input int b, input int n, input int max_gap);
        bit wr;
        for (int k = 0; k < n; k++) begin
            wr = (b == 0) && ($urandom_range(1, 0) == 1);
            repeat ($urandom_range(max_gap, 0)) @(negedge clk);
            access(b, wr, AW'($urandom), sdram_pkg::word_t'($urandom),
                   sdram_pkg::mask_t'($urandom));
        end
    endtask

    task automatic end_test(input int num, input string name, input int n);
        repeat (2) @(negedge clk);   // let the checker see the last rdy
        $display("test %0d %s: %0d requests, %0d errors", num, name, n, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        logic [AW-1:0] a;
        int            b;
        void'($urandom(32'h1e4e));
        rst        = 1'b1;
        c_rd       = '0;
        ba0_wr     = 1'b0;
        ba0_din    = '0;
        ba0_din_m  = '0;
        prog_en    = 1'b0;
        prog_addr  = '0;
        prog_ba    = '0;
        prog_rd    = 1'b0;
        prog_wr    = 1'b0;
        prog_din   = '0;
        prog_din_m = '0;
        rfsh_en    = 1'b0;
        err_mark   = 0;
        for (int i = 0; i < 4; i++)
            c_addr[i] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // every word gets a value, then masked overwrites
        @(negedge clk);
        prog_en = 1'b1;
        for (int i = 0; i < 4; i++)
            for (int j = 0; j < WORDS; j++)
                prog_write(i, j, sdram_pkg::word_t'($urandom), '0);
        repeat (32)
            prog_write(int'($urandom_range(3, 0)), int'($urandom_range(WORDS - 1, 0)),
                       sdram_pkg::word_t'($urandom), sdram_pkg::mask_t'($urandom));
        repeat (RD_LAT + 2) @(negedge clk);   // download rdys drain first
        prog_en = 1'b0;
        fork
            read_bank(0);
            read_bank(1);
            read_bank(2);
            read_bank(3);
        join
        end_test(1, "download fill", N_FILL);

        for (int k = 0; k < N_READ; k++) begin
            b = 1 + int'($urandom_range(2, 0));
            access(b, 1'b0, AW'($urandom), '0, '0);
        end
        end_test(2, "bank 1-3 reads", N_READ);

        for (int k = 0; k < N_MIX / 2; k++) begin
            a = AW'($urandom);
            access(0, 1'b1, a, sdram_pkg::word_t'($urandom), sdram_pkg::mask_t'($urandom));
            access(0, 1'b0, a, '0, '0);
        end
        end_test(3, "bank 0 write/read", N_MIX);

        fork
            random_traffic(0, N_CONC / 4, 3);
            random_traffic(1, N_CONC / 4, 3);
            random_traffic(2, N_CONC / 4, 3);
            random_traffic(3, N_CONC / 4, 3);
        join
        end_test(4, "concurrent clients", N_CONC);

        @(negedge clk);
        rfsh_en = 1'b1;
        fork
            random_traffic(0, N_RFSH / 4, 0);
            random_traffic(1, N_RFSH / 4, 0);
            random_traffic(2, N_RFSH / 4, 0);
            random_traffic(3, N_RFSH / 4, 0);
        join
        rfsh_en = 1'b0;
        end_test(5, "refresh under load", N_RFSH);

        $display("5 tests, %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
